// File: filelist.f
+incdir+common
common/uart_pkg.sv
design/uart_baud_gen.sv
design/uart_fifo.sv
uart_tx/uart_tx.sv
uart_rx/uart_rx.sv
design/uart_core.sv
verification/uart_core_assertions.sv
verification/uart_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the uart testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
    --top-module uart_core_tb -f filelist.f; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vuart_core_tb 2>&1)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
  exit 0
fi

echo "simulation did not report a pass"
exit 1

// File: verification/uart_patterns.hex
// one step per line: digit 1 opcode, digits 2-3 data byte, digits 4-8 config
// opcodes 1 config, 2 loopback, 3 bad parity, 4 bad stop, 5 overflow fill, f end
100c8000
2a500000
23c00000
20000000
2ff00000
100e8000
25a00000
28100000
100f8000
25a00000
27e00000
3c300000
49600000
100c8000
50000000
f0000000

// File: verification/uart_core_tb.sv
`timescale 1ns/100ps
`include "uart_settings.svh"

module uart_core_tb import uart_pkg::*; ();

  localparam logic [3:0] OpCfg       = 4'h1;
  localparam logic [3:0] OpLoop      = 4'h2;
  localparam logic [3:0] OpBadParity = 4'h3;
  localparam logic [3:0] OpBadStop   = 4'h4;
  localparam logic [3:0] OpOverflow  = 4'h5;
  localparam logic [3:0] OpEnd       = 4'hf;

  localparam int StepsMax   = 64;
  // cycle limits for one frame and for the whole overflow burst
  localparam int FrameLimit = 2000;
  localparam int BurstLimit = 20000;
  localparam int FillCount  = `UART_FIFO_DEPTH + 1;

  logic         clk;
  logic         rst_n;
  uart_cfg_t    cfg;
  logic         tx_wvalid;
  logic [7:0]   tx_wdata;
  logic         tx_wready;
  logic         rx_rvalid;
  logic [7:0]   rx_rdata;
  logic         rx_rready;
  logic         rx_line;
  logic         tx_line;
  uart_status_t status;
  uart_evt_t    evt;
  logic         inject_mode;
  logic         inject_bit;

  logic [31:0]  steps [StepsMax];
  logic [7:0]   fill_q [$];
  logic [31:0]  lcg_state;
  int           frame_cnt = 0;
  int           parity_cnt = 0;
  int           ovf_cnt = 0;
  int           err_cnt = 0;
  int           test_cnt = 0;
  int           fail_cnt = 0;
  int           cur_step = 0;
  bit           aborted = 1'b0;

  uart_core dut_i (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .cfg_i       (cfg),
    .tx_wvalid_i (tx_wvalid),
    .tx_wdata_i  (tx_wdata),
    .tx_wready_o (tx_wready),
    .rx_rvalid_o (rx_rvalid),
    .rx_rdata_o  (rx_rdata),
    .rx_rready_i (rx_rready),
    .rx_i        (rx_line),
    .tx_o        (tx_line),
    .status_o    (status),
    .evt_o       (evt)
  );

  bind uart_core uart_core_assertions u_assertions (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .tx_wready_i (tx_wready_o),
    .rx_rvalid_i (rx_rvalid_o),
    .tx_i        (tx_o),
    .status_i    (status_o),
    .evt_i       (evt_o)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // the serial line loops back unless a frame is bit-banged
  assign rx_line = inject_mode ? inject_bit : tx_line;

  // event pulses counted on the quiet edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (evt.frame_err) frame_cnt++;
      if (evt.parity_err) parity_cnt++;
      if (evt.rx_overflow) ovf_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // parity bit that makes the count of ones even, or odd when odd is set
  function automatic logic parity_of(input logic [7:0] d, input logic odd);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) begin
      ones += d[i];
    end
    return ((ones % 2) == 1) ? !odd : odd;
  endfunction

  function automatic int cycles_per_bit();
    return (`UART_OVERSAMPLE * 65536) / int'(cfg.nco);
  endfunction

  task automatic report_mismatch(input string msg);
    $display("ERR @%0t: step %0d %s", $time, cur_step, msg);
    err_cnt++;
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout in step %0d while waiting for %s", cur_step, what);
    err_cnt++;
    aborted = 1'b1;
  endtask

  task automatic close_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt != errs_before) begin
      fail_cnt++;
      $display("%s: failed", name);
    end else begin
      $display("%s: passed", name);
    end
  endtask

  task automatic wait_line_idle(input int limit);
    int n;
    n = 0;
    while (!(status.tx_idle && status.rx_idle) && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!(status.tx_idle && status.rx_idle)) stop_on_timeout("an idle line");
  endtask

  task automatic write_byte(input logic [7:0] b);
    int n;
    n = 0;
    while (!tx_wready && n < FrameLimit) begin
      @(negedge clk);
      n++;
    end
    if (!tx_wready) begin
      stop_on_timeout("tx fifo space");
    end else begin
      tx_wvalid = 1'b1;
      tx_wdata  = b;
      @(negedge clk);
      tx_wvalid = 1'b0;
    end
  endtask

  task automatic read_byte(output logic [7:0] b);
    int n;
    n = 0;
    b = '0;
    while (!rx_rvalid && n < FrameLimit) begin
      @(negedge clk);
      n++;
    end
    if (!rx_rvalid) begin
      stop_on_timeout("a received byte");
    end else begin
      b = rx_rdata;
      rx_rready = 1'b1;
      @(negedge clk);
      rx_rready = 1'b0;
    end
  endtask

  // counters change on the falling edge and are read on the rising one
  task automatic snapshot_events(output int frm, output int par, output int ovf);
    @(posedge clk);
    frm = frame_cnt;
    par = parity_cnt;
    ovf = ovf_cnt;
    @(negedge clk);
  endtask

  task automatic check_events(input int frm, input int par, input int ovf);
    @(posedge clk);
    if (frame_cnt != frm || parity_cnt != par || ovf_cnt != ovf) begin
      report_mismatch($sformatf("events frame %0d parity %0d overflow %0d, expected %0d %0d %0d",
                                frame_cnt, parity_cnt, ovf_cnt, frm, par, ovf));
    end
    @(negedge clk);
  endtask

  // start, 8 data bits lsb first, optional parity, stop, then one idle bit
  task automatic drive_frame(input logic [7:0] data, input logic par, input logic stop);
    int bits;
    bits = cycles_per_bit();
    inject_bit = 1'b0;
    repeat (bits) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      inject_bit = data[i];
      repeat (bits) @(negedge clk);
    end
    if (cfg.parity_en) begin
      inject_bit = par;
      repeat (bits) @(negedge clk);
    end
    inject_bit = stop;
    repeat (bits) @(negedge clk);
    inject_bit = 1'b1;
    repeat (bits) @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////
  // test steps
  ////////////////////////////////////////////////////////////

  task automatic check_reset_state();
    int errs0;
    errs0 = err_cnt;
    if (tx_line !== 1'b1) report_mismatch("tx_o not high after reset");
    if (status.txlvl != '0 || status.rxlvl != '0) report_mismatch("fifo level not zero");
    if (!status.tx_idle || !status.rx_idle) report_mismatch("idle bits not set");
    if (rx_rvalid) report_mismatch("rx_rvalid_o set after reset");
    if (evt != '0) report_mismatch("event set after reset");
    if (!tx_wready) report_mismatch("tx_wready_o low after reset");
    close_test("reset state", errs0);
  endtask

  task automatic run_loopback(input logic [7:0] data);
    int         errs0;
    int         frm0;
    int         par0;
    int         ovf0;
    logic [7:0] got;
    errs0 = err_cnt;
    snapshot_events(frm0, par0, ovf0);
    write_byte(data);
    read_byte(got);
    if (!aborted && got != data) begin
      report_mismatch($sformatf("loopback read %02h, expected %02h", got, data));
    end
    wait_line_idle(FrameLimit);
    check_events(frm0, par0, ovf0);
    close_test($sformatf("step %0d loopback %02h", cur_step, data), errs0);
  endtask

  // bad_parity flips the parity bit and a clear bad_parity sends a stop bit of 0
  task automatic run_inject(input logic [7:0] data, input logic bad_parity);
    int                     errs0;
    int                     frm0;
    int                     par0;
    int                     ovf0;
    logic [`UART_LVL_W-1:0] lvl0;
    logic                   par;
    errs0 = err_cnt;
    wait_line_idle(FrameLimit);
    snapshot_events(frm0, par0, ovf0);
    lvl0 = status.rxlvl;
    par  = parity_of(data, cfg.parity_odd);
    inject_bit  = 1'b1;
    inject_mode = 1'b1;
    @(negedge clk);
    if (bad_parity) begin
      drive_frame(data, ~par, 1'b1);
    end else begin
      drive_frame(data, par, 1'b0);
    end
    wait_line_idle(FrameLimit);
    inject_mode = 1'b0;
    if (bad_parity) begin
      check_events(frm0, par0 + 1, ovf0);
    end else begin
      check_events(frm0 + 1, par0, ovf0);
    end
    if (status.rxlvl != lvl0) report_mismatch("rx level changed by a bad frame");
    close_test($sformatf("step %0d bad %s %02h", cur_step,
                         bad_parity ? "parity" : "stop", data), errs0);
  endtask

  task automatic run_overflow();
    int         errs0;
    int         frm0;
    int         par0;
    int         ovf0;
    logic [7:0] got;
    errs0 = err_cnt;
    wait_line_idle(FrameLimit);
    snapshot_events(frm0, par0, ovf0);
    fill_q.delete();
    for (int i = 0; i < FillCount; i++) begin
      lcg_state = lcg_next(lcg_state);
      fill_q.push_back(lcg_state[23:16]);
      write_byte(lcg_state[23:16]);
    end
    wait_line_idle(BurstLimit);
    check_events(frm0, par0, ovf0 + 1);
    if (status.rxlvl != `UART_LVL_W'(`UART_FIFO_DEPTH)) begin
      report_mismatch($sformatf("rx level %0d after the burst", status.rxlvl));
    end
    for (int i = 0; i < `UART_FIFO_DEPTH; i++) begin
      read_byte(got);
      if (!aborted && got != fill_q[i]) begin
        report_mismatch($sformatf("byte %0d read %02h, expected %02h", i, got, fill_q[i]));
      end
    end
    if (status.rxlvl != '0) report_mismatch("rx fifo not empty after readout");
    close_test($sformatf("step %0d overflow fill", cur_step), errs0);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] step;
    logic [3:0]  op;
    logic [7:0]  data;
    cfg         = '0;
    tx_wvalid   = 1'b0;
    tx_wdata    = '0;
    rx_rready   = 1'b0;
    inject_mode = 1'b0;
    inject_bit  = 1'b1;
    rst_n       = 1'b0;
    lcg_state   = 32'd60577;
    $readmemh("verification/uart_patterns.hex", steps);
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_reset_state();

    while (!aborted && cur_step < StepsMax) begin
      step = steps[cur_step];
      op   = step[31:28];
      data = step[27:20];
      if (op == OpEnd) break;
      case (op)
        OpCfg: begin
          wait_line_idle(FrameLimit);
          cfg = step[19:0];
          $display("step %0d config %05h", cur_step, step[19:0]);
        end
        OpLoop:      run_loopback(data);
        OpBadParity: run_inject(data, 1'b1);
        OpBadStop:   run_inject(data, 1'b0);
        OpOverflow:  run_overflow();
        default: begin
          $display("step %0d holds an unknown opcode %0h", cur_step, op);
          err_cnt++;
          aborted = 1'b1;
        end
      endcase
      cur_step++;
    end

    $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: verification/uart_core_assertions.sv
`timescale 1ns/100ps
`include "uart_settings.svh"

module uart_core_assertions import uart_pkg::*; (
  input logic         clk_i,
  input logic         rst_ni,
  input logic         tx_wready_i,
  input logic         rx_rvalid_i,
  input logic         tx_i,
  input uart_status_t status_i,
  input uart_evt_t    evt_i
);

  localparam logic [`UART_LVL_W-1:0] LvlFull = `UART_LVL_W'(`UART_FIFO_DEPTH);

  // tx fifo only pushes back when it is really full
  tx_stall_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !tx_wready_i |-> (status_i.txlvl == LvlFull))
    else $error("tx_wready_o low while the tx fifo is not full");

  rx_overflow_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    evt_i.rx_overflow |-> (status_i.rxlvl == LvlFull))
    else $error("rx_overflow while the rx fifo is not full");

  rx_valid_matches_level: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_rvalid_i == (status_i.rxlvl != '0))
    else $error("rx_rvalid_o disagrees with the rx fifo level");

  // idle transmitter keeps the line high
  tx_line_high_when_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    status_i.tx_idle |-> tx_i)
    else $error("tx_o low while the transmitter is idle");

endmodule

// File: design/uart_core.sv
`timescale 1ns/100ps
`include "uart_settings.svh"

module uart_core import uart_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  uart_cfg_t               cfg_i,
  // host write side of the tx fifo
  input  logic                    tx_wvalid_i,
  input  logic [`UART_DATA_W-1:0] tx_wdata_i,
  output logic                    tx_wready_o,
  // host read side of the rx fifo
  output logic                    rx_rvalid_o,
  output logic [`UART_DATA_W-1:0] rx_rdata_o,
  input  logic                    rx_rready_i,
  // serial line
  input  logic                    rx_i,
  output logic                    tx_o,
  output uart_status_t            status_o,
  output uart_evt_t               evt_o
);

  logic                    tick_x16;
  logic                    tx_fifo_rvalid;
  logic                    tx_fifo_rready;
  logic [`UART_DATA_W-1:0] tx_fifo_rdata;
  logic [`UART_LVL_W-1:0]  tx_lvl;
  logic                    tx_idle;
  logic                    tx_line;
  logic                    tx_out_q;
  logic                    rx_valid;
  logic [`UART_DATA_W-1:0] rx_data;
  logic                    rx_fifo_wready;
  logic [`UART_LVL_W-1:0]  rx_lvl;
  logic                    rx_idle;
  logic                    frame_err;
  logic                    parity_err;

  // shared 16x tick, runs while either direction is on
  uart_baud_gen u_baud_gen (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .en_i       (cfg_i.tx_en | cfg_i.rx_en),
    .nco_i      (cfg_i.nco),
    .tick_x16_o (tick_x16)
  );

  //////////////////////////////////////////////////////////
  // transmit chain, host to fifo to serializer
  //////////////////////////////////////////////////////////

  uart_fifo u_tx_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (tx_wvalid_i),
    .wready_o (tx_wready_o),
    .wdata_i  (tx_wdata_i),
    .rvalid_o (tx_fifo_rvalid),
    .rready_i (tx_fifo_rready),
    .rdata_o  (tx_fifo_rdata),
    .lvl_o    (tx_lvl)
  );

  uart_tx u_tx (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .tx_en_i       (cfg_i.tx_en),
    .tick_x16_i    (tick_x16),
    .parity_en_i   (cfg_i.parity_en),
    .parity_odd_i  (cfg_i.parity_odd),
    .fifo_rvalid_i (tx_fifo_rvalid),
    .fifo_rdata_i  (tx_fifo_rdata),
    .fifo_rready_o (tx_fifo_rready),
    .idle_o        (tx_idle),
    .tx_o          (tx_line)
  );

  // glitch-free line output, idles high out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tx_out_q <= 1'b1;
    end else begin
      tx_out_q <= tx_line;
    end
  end

  assign tx_o = tx_out_q;

  //////////////////////////////////////////////////////////
  // receive chain, deserializer to fifo to host
  //////////////////////////////////////////////////////////

  uart_rx u_rx (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rx_en_i      (cfg_i.rx_en),
    .tick_x16_i   (tick_x16),
    .parity_en_i  (cfg_i.parity_en),
    .parity_odd_i (cfg_i.parity_odd),
    .rx_i         (rx_i),
    .valid_o      (rx_valid),
    .data_o       (rx_data),
    .frame_err_o  (frame_err),
    .parity_err_o (parity_err),
    .idle_o       (rx_idle)
  );

  // rx_valid only fires for clean bytes
  uart_fifo u_rx_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (rx_valid),
    .wready_o (rx_fifo_wready),
    .wdata_i  (rx_data),
    .rvalid_o (rx_rvalid_o),
    .rready_i (rx_rready_i),
    .rdata_o  (rx_rdata_o),
    .lvl_o    (rx_lvl)
  );

  // status and events
  assign status_o.txlvl   = tx_lvl;
  assign status_o.rxlvl   = rx_lvl;
  assign status_o.tx_idle = tx_idle & ~tx_fifo_rvalid;
  assign status_o.rx_idle = rx_idle;

  assign evt_o.frame_err   = frame_err;
  assign evt_o.parity_err  = parity_err;
  // good byte arriving at a full fifo is lost
  assign evt_o.rx_overflow = rx_valid & ~rx_fifo_wready;

endmodule

// File: uart_rx/uart_rx.sv
`timescale 1ns/100ps
`include "uart_settings.svh"

module uart_rx import uart_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    rx_en_i,
  input  logic                    tick_x16_i,
  input  logic                    parity_en_i,
  input  logic                    parity_odd_i,
  input  logic                    rx_i,
  output logic                    valid_o,
  output logic [`UART_DATA_W-1:0] data_o,
  output logic                    frame_err_o,
  output logic                    parity_err_o,
  output logic                    idle_o
);

  localparam int unsigned TickW = $clog2(`UART_OVERSAMPLE);
  localparam int unsigned BitW  = $clog2(`UART_DATA_W);

  logic [1:0]              sync_q;
  logic                    rx_s;
  logic                    rx_prev_q;
  rx_state_e               state_q;
  logic [TickW-1:0]        tick_cnt_q;
  logic [BitW-1:0]         bit_idx_q;
  logic [`UART_DATA_W-1:0] shift_q;
  logic                    par_bit_q;
  logic                    valid_q;
  logic                    frame_err_q;
  logic                    parity_err_q;
  logic                    sample;
  logic                    par_bad;

  //////////////////////////////////////////////////////////
  // input synchronizer, idles high like the line
  //////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_q    <= 2'b11;
      rx_prev_q <= 1'b1;
    end else begin
      sync_q    <= {sync_q[0], rx_i};
      rx_prev_q <= rx_s;
    end
  end

  assign rx_s = sync_q[1];

  //////////////////////////////////////////////////////////
  // deserializer
  //////////////////////////////////////////////////////////

  // mid-bit point of data, parity and stop bits
  assign sample  = tick_x16_i & (tick_cnt_q == TickW'(`UART_OVERSAMPLE - 1));
  assign par_bad = parity_en_i & (par_bit_q != ((^shift_q) ^ parity_odd_i));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= RX_IDLE;
      tick_cnt_q   <= '0;
      bit_idx_q    <= '0;
      valid_q      <= 1'b0;
      frame_err_q  <= 1'b0;
      parity_err_q <= 1'b0;
    end else begin
      valid_q      <= 1'b0;
      frame_err_q  <= 1'b0;
      parity_err_q <= 1'b0;
      unique case (state_q)
        RX_IDLE: begin
          tick_cnt_q <= '0;
          bit_idx_q  <= '0;
          // only a falling edge starts a frame, so a stuck low line waits
          if (rx_en_i && rx_prev_q && !rx_s) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          if (tick_x16_i) begin
            if (tick_cnt_q == TickW'(`UART_OVERSAMPLE / 2 - 1)) begin
              tick_cnt_q <= '0;
              // glitch shorter than half a bit goes back to idle
              state_q    <= rx_s ? RX_IDLE : RX_DATA;
            end else begin
              tick_cnt_q <= tick_cnt_q + 1'b1;
            end
          end
        end
        RX_DATA: begin
          if (tick_x16_i) begin
            tick_cnt_q <= tick_cnt_q + 1'b1;
          end
          if (sample) begin
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == BitW'(`UART_DATA_W - 1)) begin
              state_q <= parity_en_i ? RX_PARITY : RX_STOP;
            end
          end
        end
        RX_PARITY: begin
          if (tick_x16_i) begin
            tick_cnt_q <= tick_cnt_q + 1'b1;
          end
          if (sample) begin
            state_q <= RX_STOP;
          end
        end
        default: begin
          if (tick_x16_i) begin
            tick_cnt_q <= tick_cnt_q + 1'b1;
          end
          if (sample) begin
            state_q <= RX_IDLE;
            // one result pulse per frame, frame error wins over parity
            if (!rx_s) begin
              frame_err_q <= 1'b1;
            end else if (par_bad) begin
              parity_err_q <= 1'b1;
            end else begin
              valid_q <= 1'b1;
            end
          end
        end
      endcase
    end
  end

  // byte assembly, lsb arrives first
  always_ff @(posedge clk_i) begin
    if ((state_q == RX_DATA) && sample) begin
      shift_q <= {rx_s, shift_q[`UART_DATA_W-1:1]};
    end
    if ((state_q == RX_PARITY) && sample) begin
      par_bit_q <= rx_s;
    end
  end

  assign valid_o      = valid_q;
  assign data_o       = shift_q;
  assign frame_err_o  = frame_err_q;
  assign parity_err_o = parity_err_q;
  assign idle_o       = (state_q == RX_IDLE);

endmodule

// File: uart_tx/uart_tx.sv
`timescale 1ns/100ps
`include "uart_settings.svh"

module uart_tx import uart_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   tx_en_i,
  input  logic                   tick_x16_i,
  input  logic                   parity_en_i,
  input  logic                   parity_odd_i,
  input  logic                   fifo_rvalid_i,
  input  logic [`UART_DATA_W-1:0] fifo_rdata_i,
  output logic                   fifo_rready_o,
  output logic                   idle_o,
  output logic                   tx_o
);

  localparam int unsigned TickW = $clog2(`UART_OVERSAMPLE);
  localparam int unsigned BitW  = $clog2(`UART_DATA_W);

  tx_state_e               state_q;
  logic [TickW-1:0]        tick_cnt_q;
  logic [BitW-1:0]         bit_idx_q;
  logic [`UART_DATA_W-1:0] shift_q;
  logic                    parity_q;
  logic                    bit_end;

  // pop one byte whenever idle and enabled
  assign fifo_rready_o = (state_q == TX_IDLE) & tx_en_i & fifo_rvalid_i;
  assign idle_o        = (state_q == TX_IDLE);
  assign bit_end       = tick_x16_i & (tick_cnt_q == TickW'(`UART_OVERSAMPLE - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= TX_IDLE;
      tick_cnt_q <= '0;
      bit_idx_q  <= '0;
    end else if (state_q == TX_IDLE) begin
      tick_cnt_q <= '0;
      bit_idx_q  <= '0;
      if (fifo_rready_o) begin
        state_q <= TX_START;
      end
    end else if (tick_x16_i) begin
      // counter wraps every 16 ticks, one bit time
      tick_cnt_q <= tick_cnt_q + 1'b1;
      if (bit_end) begin
        unique case (state_q)
          TX_START:  state_q <= TX_DATA;
          TX_DATA: begin
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == BitW'(`UART_DATA_W - 1)) begin
              state_q <= parity_en_i ? TX_PARITY : TX_STOP;
            end
          end
          TX_PARITY: state_q <= TX_STOP;
          default:   state_q <= TX_IDLE;
        endcase
      end
    end
  end

  // payload, parity is worked out as the byte is loaded
  always_ff @(posedge clk_i) begin
    if (fifo_rready_o) begin
      shift_q  <= fifo_rdata_i;
      parity_q <= (^fifo_rdata_i) ^ parity_odd_i;
    end else if ((state_q == TX_DATA) && bit_end) begin
      shift_q <= shift_q >> 1;
    end
  end

  always_comb begin
    unique case (state_q)
      TX_START:  tx_o = 1'b0;
      TX_DATA:   tx_o = shift_q[0];
      TX_PARITY: tx_o = parity_q;
      default:   tx_o = 1'b1;
    endcase
  end

endmodule

// File: design/uart_fifo.sv
`timescale 1ns/100ps
`include "uart_settings.svh"

module uart_fifo #(
  parameter int unsigned Width = `UART_DATA_W,
  parameter int unsigned Depth = `UART_FIFO_DEPTH
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   wvalid_i,
  output logic                   wready_o,
  input  logic [Width-1:0]       wdata_i,
  output logic                   rvalid_o,
  input  logic                   rready_i,
  output logic [Width-1:0]       rdata_o,
  output logic [`UART_LVL_W-1:0] lvl_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;

  logic [Width-1:0]       mem_q [Depth];
  logic [PtrW-1:0]        wptr_q;
  logic [PtrW-1:0]        rptr_q;
  logic [`UART_LVL_W-1:0] lvl_q;
  logic                   push;
  logic                   pop;

  assign wready_o = (lvl_q != `UART_LVL_W'(Depth));
  assign rvalid_o = (lvl_q != '0);
  assign push     = wvalid_i & wready_o;
  assign pop      = rready_i & rvalid_o;

  // pointers and level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      lvl_q  <= '0;
    end else begin
      if (push) begin
        wptr_q <= (wptr_q == PtrW'(Depth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == PtrW'(Depth - 1)) ? '0 : rptr_q + 1'b1;
      end
      // push and pop together leave the level alone
      if (push && !pop) begin
        lvl_q <= lvl_q + 1'b1;
      end else if (pop && !push) begin
        lvl_q <= lvl_q - 1'b1;
      end
    end
  end

  // storage array
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

  // head of queue shows whenever rvalid is high
  assign rdata_o = mem_q[rptr_q];
  assign lvl_o   = lvl_q;

endmodule

// File: design/uart_baud_gen.sv
`timescale 1ns/100ps
`include "uart_settings.svh"

module uart_baud_gen (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   en_i,
  input  logic [`UART_NCO_W-1:0] nco_i,
  output logic                   tick_x16_o
);

  // one extra msb catches the carry of each add
  logic [`UART_NCO_W:0] acc_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (en_i) begin
      // drop the old carry before adding again
      acc_q <= {1'b0, acc_q[`UART_NCO_W-1:0]} + {1'b0, nco_i};
    end
  end

  // carry out is the 16x tick, high for one cycle per wrap
  assign tick_x16_o = acc_q[`UART_NCO_W];

endmodule

// File: common/uart_pkg.sv
`include "uart_settings.svh"

package uart_pkg;

  // static configuration from the host
  typedef struct packed {
    logic                   tx_en;
    logic                   rx_en;
    logic                   parity_en;
    logic                   parity_odd;
    logic [`UART_NCO_W-1:0] nco;
  } uart_cfg_t;

  // fifo levels and line idle flags
  typedef struct packed {
    logic [`UART_LVL_W-1:0] txlvl;
    logic [`UART_LVL_W-1:0] rxlvl;
    logic                   tx_idle;
    logic                   rx_idle;
  } uart_status_t;

  // one-cycle error events
  typedef struct packed {
    logic frame_err;
    logic parity_err;
    logic rx_overflow;
  } uart_evt_t;

  typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP} tx_state_e;

  typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP} rx_state_e;

endpackage

// File: common/uart_settings.svh
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// character width in bits
`define UART_DATA_W 8

// entries per fifo, and a level wide enough to hold the full count
`define UART_FIFO_DEPTH 32
`define UART_LVL_W 6

// nco increment width, tick rate is fclk * nco / 2**UART_NCO_W
`define UART_NCO_W 16

// baud ticks per serial bit
`define UART_OVERSAMPLE 16

`endif
